// ==== logic/slm_pkg.sv ====
// Shared definitions for the SLM controller bridge
// Widths and timing constants for UART and SPI
// Command characters and SPI register frames
// Decoder to SPI request struct and the FSM state enums

package slm_pkg;

  ////////////////////////////////////////////////////////////
  // Timing and sizes
  ////////////////////////////////////////////////////////////

  // 50 MHz / 115200 baud
  localparam int UART_CLKS_PER_BIT = 434;
  localparam int SPI_HALF_PERIOD   = 25;
  localparam int SPI_FRAME_BITS    = 16;
  // At least tReset on the modulator
  localparam int RESET_HOLD_CYCLES = 10;
  localparam int REPLY_DEPTH       = 4;

  // Counter and pointer widths
  typedef logic [7:0]                               byte_t;
  typedef logic [2:0]                               uart_bit_t;
  typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0]     uart_cnt_t;
  typedef logic [$clog2(SPI_HALF_PERIOD)-1:0]       spi_cnt_t;
  typedef logic [$clog2(SPI_FRAME_BITS)-1:0]        spi_bit_t;
  typedef logic [$clog2(RESET_HOLD_CYCLES + 1)-1:0] hold_cnt_t;
  typedef logic [$clog2(REPLY_DEPTH)-1:0]           reply_ptr_t;
  typedef logic [$clog2(REPLY_DEPTH + 1)-1:0]       reply_cnt_t;

  ////////////////////////////////////////////////////////////
  // SPI frame and request
  ////////////////////////////////////////////////////////////

  // Address byte goes out first
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_frame_t;

  typedef struct packed {
    logic       start;
    spi_frame_t frame;
  } spi_req_t;

  // ASCII command characters from the PC
  localparam byte_t CMD_RESET    = 8'h72;
  localparam byte_t CMD_WHOAMI   = 8'h64;
  localparam byte_t CMD_SET_CLK  = 8'h73;
  localparam byte_t CMD_READ_CLK = 8'h61;

  // Identity read, clock set to 50, clock read back
  localparam spi_frame_t FRAME_WHOAMI   = '{addr: 8'hF8, data: 8'h00};
  localparam spi_frame_t FRAME_SET_CLK  = '{addr: 8'h09, data: 8'h32};
  localparam spi_frame_t FRAME_READ_CLK = '{addr: 8'h89, data: 8'h00};

  // State enums
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT_LOW, SPI_SHIFT_HIGH, SPI_DONE} spi_state_t;

endpackage

// ==== logic/uart_rx.sv ====
// UART receiver for the PC command link
// Two-flop line synchronizer and mid-bit start check
// One-cycle strobe at the middle of the stop bit

`timescale 1ns/1ns

module uart_rx (
  input  logic               i_sys_clk,
  input  logic               i_reset_all_cmd_w,
  input  logic               i_serial,
  output logic               o_valid,
  output slm_pkg::byte_t     o_byte
);

  logic                 rx_meta;
  logic                 rx_sync;
  slm_pkg::uart_state_t state;
  slm_pkg::uart_cnt_t   clk_cnt;
  slm_pkg::uart_bit_t   bit_idx;
  slm_pkg::byte_t       data_sr;

  // Line idles high
  always_ff @(posedge i_sys_clk) begin
    if (i_reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_serial;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_reset_all_cmd_w) begin
      state   <= slm_pkg::UART_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      // Strobe lasts one cycle
      o_valid <= 1'b0;
      case (state)
        slm_pkg::UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync) state <= slm_pkg::UART_START;
        end
        slm_pkg::UART_START: begin
          // Recheck at half a bit to reject glitches
          if (clk_cnt == slm_pkg::uart_cnt_t'((slm_pkg::UART_CLKS_PER_BIT - 1) / 2)) begin
            clk_cnt <= '0;
            state   <= rx_sync ? slm_pkg::UART_IDLE : slm_pkg::UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        slm_pkg::UART_DATA: begin
          if (clk_cnt == slm_pkg::uart_cnt_t'(slm_pkg::UART_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            // LSB arrives first
            data_sr <= {rx_sync, data_sr[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= slm_pkg::UART_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        slm_pkg::UART_STOP: begin
          // Middle of the stop bit
          if (clk_cnt == slm_pkg::uart_cnt_t'(slm_pkg::UART_CLKS_PER_BIT - 1)) begin
            o_valid <= 1'b1;
            o_byte  <= data_sr;
            state   <= slm_pkg::UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/cmd_decode.sv ====
// Command character decoder
// Maps PC characters onto SPI register frames
// Reset pulse stretcher for the SPI side and the modulator pin

`timescale 1ns/1ns

module cmd_decode (
  input  logic               i_sys_clk,
  input  logic               i_reset_all_cmd_w,
  input  logic               i_valid,
  input  slm_pkg::byte_t     i_byte,
  output slm_pkg::spi_req_t  o_req,
  output logic               o_sub_reset,
  output logic               o_slm_reset_n
);

  slm_pkg::hold_cnt_t  hold_cnt;
  logic                cmd_known;
  slm_pkg::spi_frame_t cmd_frame;
  logic                req_start;
  slm_pkg::spi_frame_t req_frame;

  // Character lookup
  always_comb begin
    cmd_known = 1'b1;
    cmd_frame = slm_pkg::FRAME_WHOAMI;
    case (i_byte)
      slm_pkg::CMD_WHOAMI:   cmd_frame = slm_pkg::FRAME_WHOAMI;
      slm_pkg::CMD_SET_CLK:  cmd_frame = slm_pkg::FRAME_SET_CLK;
      slm_pkg::CMD_READ_CLK: cmd_frame = slm_pkg::FRAME_READ_CLK;
      default:               cmd_known = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Reset stretcher
  ////////////////////////////////////////////////////////////

  // Load on trigger then count down
  always_ff @(posedge i_sys_clk) begin
    if (i_reset_all_cmd_w || (i_valid && i_byte == slm_pkg::CMD_RESET)) begin
      hold_cnt    <= slm_pkg::hold_cnt_t'(slm_pkg::RESET_HOLD_CYCLES);
      o_sub_reset <= 1'b1;
    end else if (hold_cnt != '0) begin
      hold_cnt    <= hold_cnt - 1'b1;
      o_sub_reset <= 1'b1;
    end else begin
      o_sub_reset <= 1'b0;
    end
  end

  // Modulator reset pin is active low
  assign o_slm_reset_n = ~o_sub_reset;

  ////////////////////////////////////////////////////////////
  // SPI request
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_sys_clk) begin
    if (i_reset_all_cmd_w) begin
      req_start <= 1'b0;
    end else begin
      req_start <= i_valid & cmd_known;
    end
  end

  // Frame held until the next known command
  always_ff @(posedge i_sys_clk) begin
    if (i_valid && cmd_known) req_frame <= cmd_frame;
  end

  assign o_req = '{start: req_start, frame: req_frame};

endmodule

// ==== logic/spi_master.sv ====
// 16-bit mode-0 SPI master for the modulator register port
// Chip select low for the whole frame
// Return byte taken from the last eight sampled bits

`timescale 1ns/1ns

module spi_master (
  input  logic              i_sys_clk,
  input  logic              i_sub_reset,
  input  slm_pkg::spi_req_t i_req,
  input  logic              i_miso,
  output logic              o_busy,
  output logic              o_cs_n,
  output logic              o_sclk,
  output logic              o_mosi,
  output slm_pkg::byte_t    o_rx_byte
);

  slm_pkg::spi_state_t                state;
  slm_pkg::spi_cnt_t                  div_cnt;
  slm_pkg::spi_bit_t                  bit_cnt;
  logic [slm_pkg::SPI_FRAME_BITS-1:0] tx_shift;
  slm_pkg::byte_t                     rx_shift;
  logic                               half_done;

  // End of one SCK half period
  assign half_done = (div_cnt == slm_pkg::spi_cnt_t'(slm_pkg::SPI_HALF_PERIOD - 1));

  always_ff @(posedge i_sys_clk) begin
    if (i_sub_reset) begin
      state   <= slm_pkg::SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      o_busy  <= 1'b0;
      o_cs_n  <= 1'b1;
      o_sclk  <= 1'b0;
      o_mosi  <= 1'b0;
    end else begin
      case (state)
        slm_pkg::SPI_IDLE: begin
          // Start ignored unless idle
          if (i_req.start) begin
            tx_shift <= i_req.frame;
            // First bit ready as SEN falls
            o_mosi   <= i_req.frame.addr[7];
            o_busy   <= 1'b1;
            o_cs_n   <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            state    <= slm_pkg::SPI_SHIFT_LOW;
          end
        end
        slm_pkg::SPI_SHIFT_LOW: begin
          if (half_done) begin
            div_cnt  <= '0;
            o_sclk   <= 1'b1;
            // Sample on the rising edge
            rx_shift <= {rx_shift[6:0], i_miso};
            state    <= slm_pkg::SPI_SHIFT_HIGH;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        slm_pkg::SPI_SHIFT_HIGH: begin
          if (half_done) begin
            div_cnt <= '0;
            o_sclk  <= 1'b0;
            if (bit_cnt == slm_pkg::spi_bit_t'(slm_pkg::SPI_FRAME_BITS - 1)) begin
              state <= slm_pkg::SPI_DONE;
            end else begin
              // Next bit while SCK is low
              bit_cnt  <= bit_cnt + 1'b1;
              tx_shift <= {tx_shift[slm_pkg::SPI_FRAME_BITS-2:0], 1'b0};
              o_mosi   <= tx_shift[slm_pkg::SPI_FRAME_BITS-2];
              state    <= slm_pkg::SPI_SHIFT_LOW;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        slm_pkg::SPI_DONE: begin
          // One cycle after the last falling edge
          o_busy    <= 1'b0;
          o_cs_n    <= 1'b1;
          o_mosi    <= 1'b0;
          o_rx_byte <= rx_shift;
          state     <= slm_pkg::SPI_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/reply_queue.sv ====
// Reply queue between the SPI master and the UART transmitter
// Writes the return byte when SPI busy falls
// Reads the head entry when the transmitter is idle

`timescale 1ns/1ns

module reply_queue (
  input  logic           i_sys_clk,
  input  logic           i_sub_reset,
  input  logic           i_spi_busy,
  input  slm_pkg::byte_t i_rx_byte,
  input  logic           i_tx_busy,
  output logic           o_send,
  output slm_pkg::byte_t o_send_byte
);

  slm_pkg::byte_t      mem [slm_pkg::REPLY_DEPTH];
  slm_pkg::reply_ptr_t wr_ptr;
  slm_pkg::reply_ptr_t rd_ptr;
  slm_pkg::reply_cnt_t count;
  logic                spi_busy_q;
  logic                full;
  logic                empty;
  logic                do_write;
  logic                do_read;

  assign full     = (count == slm_pkg::reply_cnt_t'(slm_pkg::REPLY_DEPTH));
  assign empty    = (count == '0);
  // Falling edge of SPI busy; replies dropped when full
  assign do_write = spi_busy_q & ~i_spi_busy & ~full;
  // Hold off while a send strobe is still in flight
  assign do_read  = ~empty & ~i_tx_busy & ~o_send;

  // Storage
  always_ff @(posedge i_sys_clk) begin
    if (do_write) mem[wr_ptr] <= i_rx_byte;
    if (do_read)  o_send_byte <= mem[rd_ptr];
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_sub_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      spi_busy_q <= 1'b0;
      o_send     <= 1'b0;
    end else begin
      spi_busy_q <= i_spi_busy;
      o_send     <= do_read;
      // Pointers wrap on the power-of-two depth
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/uart_tx.sv ====
// UART transmitter for replies to the PC
// 8N1 framing with a busy level over the whole character

`timescale 1ns/1ns

module uart_tx (
  input  logic           i_sys_clk,
  input  logic           i_reset_all_cmd_w,
  input  logic           i_send,
  input  slm_pkg::byte_t i_byte,
  output logic           o_busy,
  output logic           o_serial
);

  slm_pkg::uart_state_t state;
  slm_pkg::uart_cnt_t   clk_cnt;
  slm_pkg::uart_bit_t   bit_idx;
  slm_pkg::byte_t       data_sr;
  logic                 bit_done;

  assign bit_done = (clk_cnt == slm_pkg::uart_cnt_t'(slm_pkg::UART_CLKS_PER_BIT - 1));

  always_ff @(posedge i_sys_clk) begin
    if (i_reset_all_cmd_w) begin
      state    <= slm_pkg::UART_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      o_busy   <= 1'b0;
      o_serial <= 1'b1;
    end else begin
      // Count through every bit time outside idle
      clk_cnt <= (state == slm_pkg::UART_IDLE || bit_done) ? '0 : clk_cnt + 1'b1;
      case (state)
        slm_pkg::UART_IDLE: begin
          o_serial <= 1'b1;
          if (i_send) begin
            data_sr  <= i_byte;
            bit_idx  <= '0;
            o_busy   <= 1'b1;
            // Start bit
            o_serial <= 1'b0;
            state    <= slm_pkg::UART_START;
          end
        end
        slm_pkg::UART_START: begin
          if (bit_done) begin
            o_serial <= data_sr[0];
            state    <= slm_pkg::UART_DATA;
          end
        end
        slm_pkg::UART_DATA: begin
          if (bit_done) begin
            // LSB first
            data_sr <= {1'b0, data_sr[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              o_serial <= 1'b1;
              state    <= slm_pkg::UART_STOP;
            end else begin
              o_serial <= data_sr[1];
            end
          end
        end
        slm_pkg::UART_STOP: begin
          // Busy covers ten bit times
          if (bit_done) begin
            o_busy <= 1'b0;
            state  <= slm_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/slm_bridge_top.sv ====
// Top level of the SLM controller bridge
// UART command in, SPI register frames out
// Modulator reply bytes back to the PC over UART

`timescale 1ns/1ns

module slm_bridge_top (
  input  logic i_sys_clk,
  input  logic i_reset_all_cmd_w,
  input  logic i_uart_rx,
  input  logic i_sout,
  output logic o_uart_tx,
  output logic o_sen,
  output logic o_sck,
  output logic o_sdat,
  output logic o_slm_reset_n
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  logic              rx_valid;
  slm_pkg::byte_t    rx_byte;
  slm_pkg::spi_req_t spi_req;
  logic              sub_reset;
  logic              spi_busy;
  slm_pkg::byte_t    spi_rx_byte;
  logic              tx_send;
  slm_pkg::byte_t    tx_byte;
  logic              tx_busy;

  // PC command input
  uart_rx u_uart_rx (
    .i_sys_clk         (i_sys_clk),
    .i_reset_all_cmd_w (i_reset_all_cmd_w),
    .i_serial          (i_uart_rx),
    .o_valid           (rx_valid),
    .o_byte            (rx_byte)
  );

  cmd_decode u_cmd_decode (
    .i_sys_clk         (i_sys_clk),
    .i_reset_all_cmd_w (i_reset_all_cmd_w),
    .i_valid           (rx_valid),
    .i_byte            (rx_byte),
    .o_req             (spi_req),
    .o_sub_reset       (sub_reset),
    .o_slm_reset_n     (o_slm_reset_n)
  );

  // Modulator register port
  spi_master u_spi_master (
    .i_sys_clk   (i_sys_clk),
    .i_sub_reset (sub_reset),
    .i_req       (spi_req),
    .i_miso      (i_sout),
    .o_busy      (spi_busy),
    .o_cs_n      (o_sen),
    .o_sclk      (o_sck),
    .o_mosi      (o_sdat),
    .o_rx_byte   (spi_rx_byte)
  );

  reply_queue u_reply_queue (
    .i_sys_clk   (i_sys_clk),
    .i_sub_reset (sub_reset),
    .i_spi_busy  (spi_busy),
    .i_rx_byte   (spi_rx_byte),
    .i_tx_busy   (tx_busy),
    .o_send      (tx_send),
    .o_send_byte (tx_byte)
  );

  // Replies back to the PC
  uart_tx u_uart_tx (
    .i_sys_clk         (i_sys_clk),
    .i_reset_all_cmd_w (i_reset_all_cmd_w),
    .i_send            (tx_send),
    .i_byte            (tx_byte),
    .o_busy            (tx_busy),
    .o_serial          (o_uart_tx)
  );

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock source
// 4 ns period, starts low

`timescale 1ns/1ns

module tb_clock (
  output logic o_sys_clk
);

  localparam int HALF_PERIOD_NS = 2;

  initial o_sys_clk = 1'b0;

  always #(HALF_PERIOD_NS) o_sys_clk = ~o_sys_clk;

endmodule

// ==== verif/slm_bridge_asserts.sv ====
// Concurrent checks on the bridge top-level ports
// SCK idle while deselected, SEN high during modulator reset
// UART line idle right after reset

`timescale 1ns/1ns

module slm_bridge_asserts (
  input logic i_sys_clk,
  input logic i_reset_all_cmd_w,
  input logic i_uart_tx,
  input logic i_sen,
  input logic i_sck,
  input logic i_slm_reset_n
);

  // Mode 0, so SCK rests low outside a frame
  sck_low_when_deselected: assert property (
    @(posedge i_sys_clk) disable iff (i_reset_all_cmd_w) i_sen |-> !i_sck)
    else $error("SCK is high while SEN is high");

  // No frame may run while the modulator is held in reset
  sen_high_in_reset: assert property (
    @(posedge i_sys_clk) disable iff (i_reset_all_cmd_w) !i_slm_reset_n |-> i_sen)
    else $error("SEN is low while the modulator reset is active");

  // Line back to idle once reset drops
  uart_idle_after_reset: assert property (
    @(posedge i_sys_clk) $fell(i_reset_all_cmd_w) |-> i_uart_tx)
    else $error("UART line is not high in the cycle after reset");

endmodule

bind slm_bridge_top slm_bridge_asserts u_asserts (
  .i_sys_clk         (i_sys_clk),
  .i_reset_all_cmd_w (i_reset_all_cmd_w),
  .i_uart_tx         (o_uart_tx),
  .i_sen             (o_sen),
  .i_sck             (o_sck),
  .i_slm_reset_n     (o_slm_reset_n)
);

// ==== verif/slm_bridge_tb.sv ====
// Testbench top for the SLM controller bridge
// UART driver and receiver, modulator SPI model, reset pin monitor
// Directed tests, watchdog and summary

`timescale 1ns/1ns

module slm_bridge_tb;

  localparam int BIT_CLKS  = slm_pkg::UART_CLKS_PER_BIT;
  localparam int BYTE_CLKS = 10 * BIT_CLKS;
  // Byte times per test, in test order
  localparam int TEST_BYTES  = 3 + 5 + 5 + 3 + 6;
  localparam int WATCHDOG_NS = 2 * TEST_BYTES * BYTE_CLKS * 4;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx;
  logic sout = 1'b0;
  logic uart_tx;
  logic sen;
  logic sck;
  logic sdat;
  logic slm_reset_n;

  int checks    = 0;
  int errors    = 0;
  int tests_run = 0;

  // Modulator model state
  logic [15:0]    frame_q[$];
  logic [15:0]    spi_rec      = '0;
  slm_pkg::byte_t resp         = '0;
  int             spi_bits     = 0;
  int             sen_falls    = 0;
  int             short_frames = 0;
  logic           sen_q;
  logic           sck_q;

  // Reset pin monitor state
  int reset_pulses   = 0;
  int reset_run      = 0;
  int last_reset_len = 0;

  tb_clock u_clock (
    .o_sys_clk (sys_clk)
  );

  slm_bridge_top dut0 (
    .i_sys_clk         (sys_clk),
    .i_reset_all_cmd_w (reset_all_cmd_w),
    .i_uart_rx         (uart_rx),
    .i_sout            (sout),
    .o_uart_tx         (uart_tx),
    .o_sen             (sen),
    .o_sck             (sck),
    .o_sdat            (sdat),
    .o_slm_reset_n     (slm_reset_n)
  );

  ////////////////////////////////////////////////////////////
  // Modulator model and monitors
  ////////////////////////////////////////////////////////////

  // Records SDAT on rising SCK, answers with the inverted address
  always @(negedge sys_clk) begin
    if (sen_q === 1'b1 && sen === 1'b0) begin
      sen_falls++;
      spi_bits = 0;
      // Upper byte carries no answer
      sout = 1'b0;
    end else if (sen === 1'b0) begin
      if (sck === 1'b1 && sck_q === 1'b0) begin
        spi_rec = {spi_rec[14:0], sdat};
        spi_bits++;
        if (spi_bits == 8) resp = ~spi_rec[7:0];
      end else if (sck === 1'b0 && sck_q === 1'b1) begin
        // Answer bits MSB first, one per falling edge
        if (spi_bits >= 8 && spi_bits < 16) sout = resp[15 - spi_bits];
      end
    end else if (sen_q === 1'b0 && sen === 1'b1) begin
      frame_q.push_back(spi_rec);
      if (spi_bits != 16) short_frames++;
      sout = 1'b0;
    end
    sen_q = sen;
    sck_q = sck;
  end

  // Length of each low pulse on the modulator reset pin
  always @(negedge sys_clk) begin
    if (slm_reset_n === 1'b0) begin
      reset_run++;
    end else if (reset_run > 0) begin
      reset_pulses++;
      last_reset_len = reset_run;
      reset_run = 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // The modulator answers with its inverted address byte
  function automatic slm_pkg::byte_t model_reply(input slm_pkg::spi_frame_t frame);
    return ~frame.addr;
  endfunction

  // 8N1, LSB first, called on a falling edge
  task automatic send_char(input slm_pkg::byte_t ch);
    int i;
    uart_rx = 1'b0;
    repeat (BIT_CLKS) @(negedge sys_clk);
    for (i = 0; i < 8; i++) begin
      uart_rx = ch[i];
      repeat (BIT_CLKS) @(negedge sys_clk);
    end
    uart_rx = 1'b1;
    repeat (BIT_CLKS) @(negedge sys_clk);
  endtask

  // Waits for a start bit, then samples at bit centers
  task automatic receive_char(input int timeout_clks, output slm_pkg::byte_t ch,
                              output bit got);
    int waited;
    int i;
    waited = 0;
    got    = 1'b0;
    ch     = '0;
    while (uart_tx === 1'b1 && waited < timeout_clks) begin
      @(negedge sys_clk);
      waited++;
    end
    if (uart_tx !== 1'b0) return;
    repeat (BIT_CLKS / 2) @(negedge sys_clk);
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge sys_clk);
      ch[i] = uart_tx;
    end
    // Stop bit must be high
    repeat (BIT_CLKS) @(negedge sys_clk);
    got = (uart_tx === 1'b1);
  endtask

  task automatic compare_value(input string test, input string what,
                               input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic expect_true(input string test, input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR %s: %s", test, msg);
    end
  endtask

  task automatic finish_test(input string test, input int errors_before);
    tests_run++;
    if (errors == errors_before) $display("%s: ok", test);
    else $display("%s: failed with %0d errors", test, errors - errors_before);
  endtask

  // Sends commands back to back, collects one reply per expected frame
  task automatic command_exchange(input string test, input slm_pkg::byte_t cmds[$],
                                  input slm_pkg::spi_frame_t exp_frames[$]);
    slm_pkg::byte_t replies[$];
    slm_pkg::byte_t ch;
    bit             got;
    int             shorts;
    int             i;
    frame_q.delete();
    shorts = short_frames;
    fork
      begin
        foreach (cmds[k]) send_char(cmds[k]);
      end
      begin
        for (i = 0; i < exp_frames.size(); i++) begin
          receive_char(3 * BYTE_CLKS, ch, got);
          expect_true(test, got, "no valid reply byte on the UART");
          if (got) replies.push_back(ch);
        end
      end
    join
    expect_true(test, frame_q.size() == exp_frames.size(), "wrong number of SPI frames");
    expect_true(test, short_frames == shorts, "SPI frame without 16 SCK edges");
    for (i = 0; i < exp_frames.size() && i < frame_q.size(); i++) begin
      compare_value(test, $sformatf("frame %0d", i), exp_frames[i], frame_q[i]);
    end
    // Replies must come back in command order
    for (i = 0; i < exp_frames.size() && i < replies.size(); i++) begin
      compare_value(test, $sformatf("reply %0d", i),
                    16'(model_reply(exp_frames[i])), 16'(replies[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic whoami_reply();
    slm_pkg::byte_t      cmds[$];
    slm_pkg::spi_frame_t frames[$];
    int                  errs;
    errs = errors;
    cmds.push_back(slm_pkg::CMD_WHOAMI);
    frames.push_back(slm_pkg::FRAME_WHOAMI);
    command_exchange("whoami_reply", cmds, frames);
    finish_test("whoami_reply", errs);
  endtask

  task automatic clock_set_and_read();
    slm_pkg::byte_t      cmds[$];
    slm_pkg::spi_frame_t frames[$];
    int                  errs;
    errs = errors;
    cmds.push_back(slm_pkg::CMD_SET_CLK);
    frames.push_back(slm_pkg::FRAME_SET_CLK);
    command_exchange("clock_set_and_read", cmds, frames);
    cmds[0]   = slm_pkg::CMD_READ_CLK;
    frames[0] = slm_pkg::FRAME_READ_CLK;
    command_exchange("clock_set_and_read", cmds, frames);
    finish_test("clock_set_and_read", errs);
  endtask

  task automatic back_to_back_order();
    slm_pkg::byte_t      cmds[$];
    slm_pkg::spi_frame_t frames[$];
    int                  errs;
    errs = errors;
    cmds.push_back(slm_pkg::CMD_WHOAMI);
    cmds.push_back(slm_pkg::CMD_SET_CLK);
    cmds.push_back(slm_pkg::CMD_READ_CLK);
    frames.push_back(slm_pkg::FRAME_WHOAMI);
    frames.push_back(slm_pkg::FRAME_SET_CLK);
    frames.push_back(slm_pkg::FRAME_READ_CLK);
    command_exchange("back_to_back_order", cmds, frames);
    finish_test("back_to_back_order", errs);
  endtask

  task automatic unknown_char_ignored();
    slm_pkg::byte_t ch;
    bit             got;
    int             falls;
    int             errs;
    errs  = errors;
    falls = sen_falls;
    send_char(8'h78);
    receive_char(2 * BYTE_CLKS, ch, got);
    expect_true("unknown_char_ignored", !got, "UART reply to an unknown character");
    expect_true("unknown_char_ignored", sen_falls == falls, "SEN fell for an unknown character");
    finish_test("unknown_char_ignored", errs);
  endtask

  task automatic reset_then_whoami();
    slm_pkg::byte_t      cmds[$];
    slm_pkg::spi_frame_t frames[$];
    slm_pkg::byte_t      ch;
    bit                  got;
    int                  pulses;
    int                  errs;
    errs   = errors;
    pulses = reset_pulses;
    send_char(slm_pkg::CMD_RESET);
    receive_char(2 * BYTE_CLKS, ch, got);
    expect_true("reset_then_whoami", reset_pulses == pulses + 1,
                "no single reset pulse on the modulator reset pin");
    expect_true("reset_then_whoami", last_reset_len >= slm_pkg::RESET_HOLD_CYCLES,
                $sformatf("reset pulse lasted only %0d cycles", last_reset_len));
    expect_true("reset_then_whoami", slm_reset_n === 1'b1, "modulator reset pin stuck low");
    expect_true("reset_then_whoami", !got, "UART reply to the reset command");
    cmds.push_back(slm_pkg::CMD_WHOAMI);
    frames.push_back(slm_pkg::FRAME_WHOAMI);
    command_exchange("reset_then_whoami", cmds, frames);
    finish_test("reset_then_whoami", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence, watchdog and summary
  ////////////////////////////////////////////////////////////

  initial begin
    reset_all_cmd_w = 1'b1;
    uart_rx         = 1'b1;
    repeat (2) @(negedge sys_clk);
    reset_all_cmd_w = 1'b0;
    repeat (4) @(negedge sys_clk);
    whoami_reply();
    clock_set_and_read();
    back_to_back_order();
    unknown_char_ignored();
    reset_then_whoami();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Twice the summed UART byte times of all tests
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/slm_pkg.sv
logic/uart_rx.sv
logic/cmd_decode.sv
logic/spi_master.sv
logic/reply_queue.sv
logic/uart_tx.sv
logic/slm_bridge_top.sv
verif/tb_clock.sv
verif/slm_bridge_asserts.sv
verif/slm_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run for the SLM controller bridge

VERILATOR  ?= verilator
TOP        ?= slm_bridge_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
